//--- project.f
logic/isaPkg.sv
logic/pipePkg.sv
logic/regFile.sv
logic/stageReg.sv
logic/decodeUnit.sv
logic/executeUnit.sv
logic/hazardUnit.sv
logic/coreTop.sv
tests/memModel.sv
tests/coreTb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module coreTb -o coreSim

status=0
out=$(./obj_dir/coreSim) || status=$?
echo "$out"

if [ "$status" -eq 0 ] && echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- tests/coreTb.sv
`default_nettype none
`timescale 1ns/1ps

module coreTb import isaPkg::*, pipePkg::*; ();

    localparam int   clkPeriod   = 100;
    localparam int   resetCycles = 16;
    localparam int   memWords    = 256;
    localparam wordT sentinel    = 32'h1fc;
    // ALU chain twice, load-use, branches, mul
    localparam int   programWords   = 2 * 11 + 7 + 14 + 10;
    localparam int   watchdogCycles = programWords * 20;

    typedef struct packed {
        logic       instr;      // instruction or data word
        logic [7:0] idx;
        wordT       data;
    } loadT;

    logic   clk;
    logic   rstN;
    wordT   iAddr;
    wordT   iData;
    logic   iStall;
    memReqT dReq;
    wordT   dData;
    logic   dStall;
    logic   stallEn;
    logic   clear;
    logic   loadEn;
    logic   loadInstr;
    logic [7:0] loadIdx;
    wordT   loadData;
    logic   sentinelSeen;

    loadT   loads [$];
    int     progLen;
    int     errors;
    int     checks;
    wordT   aluSnapshot [memWords];

    coreTop DUT (
        .clk(clk), .rstN(rstN), .iAddr(iAddr), .iData(iData), .iStall(iStall),
        .dReq(dReq), .dData(dData), .dStall(dStall)
    );

    memModel #(.depth(memWords), .sentinel(sentinel)) mem (
        .clk(clk), .iAddr(iAddr), .iData(iData), .iStall(iStall), .dReq(dReq),
        .dData(dData), .dStall(dStall), .stallEn(stallEn), .clear(clear),
        .loadEn(loadEn), .loadInstr(loadInstr), .loadIdx(loadIdx), .loadData(loadData),
        .sentinelSeen(sentinelSeen)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic wordT regOp(functT fn, regAddrT rs, regAddrT rt, regAddrT rd);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT immOp(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jumpTo(int word);
        return {opJ, 26'(word)};
    endfunction

    task automatic putInstr(input wordT w);
        loadT e;
        e.instr = 1'b1;
        e.idx   = 8'(progLen);
        e.data  = w;
        loads.push_back(e);
        progLen++;
    endtask

    task automatic putData(input wordT addr, input wordT w);
        loadT e;
        e.instr = 1'b0;
        e.idx   = addr[9:2];
        e.data  = w;
        loads.push_back(e);
    endtask

    // clear memory, load the words while the core sits in reset, then release
    task automatic startProgram(input bit stalls);
        int c;
        @(negedge clk);
        rstN    = 1'b0;
        stallEn = 1'b0;
        clear   = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        for (c = 1; c < resetCycles || c <= loads.size(); c++) begin
            loadEn = c <= loads.size();
            if (loadEn) begin
                loadInstr = loads[c-1].instr;
                loadIdx   = loads[c-1].idx;
                loadData  = loads[c-1].data;
            end
            @(negedge clk);
        end
        loadEn  = 1'b0;
        rstN    = 1'b1;
        stallEn = stalls;
    endtask

    task automatic awaitSentinel();
        int limit;
        int waited;
        limit  = progLen * 20;
        waited = 0;
        while (!sentinelSeen && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        if (!sentinelSeen) begin
            errors++;
            $display("no store reached the sentinel address within %0d cycles (at %0d ns)",
                     limit, $time);
        end
    endtask

    task automatic checkWord(input wordT addr, input wordT exp);
        wordT got;
        got = mem.dmem[addr[9:2]];
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: dmem[0x%03h] = 0x%08h, expected 0x%08h",
                     $time, addr, got, exp);
        end
    endtask

    task automatic expectWrites(input wordT addr, input int exp);
        int got;
        got = int'(mem.wrCount[addr[9:2]]);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Error at %0d ns: writes to dmem[0x%03h] = %0d, expected %0d",
                     $time, addr, got, exp);
        end
    endtask

    // E, M and W all feed decode somewhere in this chain
    task automatic runAluChain(input bit stalls);
        wordT r1;
        wordT r2;
        wordT r3;
        wordT r4;
        wordT r5;
        wordT r6;
        wordT addr;
        int   i;
        r1 = 32'h0000_1234;
        r2 = 32'h0000_0ff0;
        r3 = r1 + r2;
        r4 = r1 - r3;   // wraps below zero
        r5 = r4 | 32'h0000_8001;
        r6 = r5 + r3;
        loads.delete();
        progLen = 0;
        putInstr(immOp(opOri, 5'd0, 5'd1, r1[15:0]));
        putInstr(immOp(opOri, 5'd0, 5'd2, r2[15:0]));
        putInstr(regOp(fnAddu, 5'd1, 5'd2, 5'd3));
        putInstr(regOp(fnSubu, 5'd1, 5'd3, 5'd4));
        putInstr(immOp(opOri, 5'd4, 5'd5, 16'h8001));
        putInstr(immOp(opSw, 5'd0, 5'd3, 16'h0100));
        putInstr(immOp(opSw, 5'd0, 5'd4, 16'h0104));
        putInstr(immOp(opSw, 5'd0, 5'd5, 16'h0108));
        putInstr(regOp(fnAddu, 5'd5, 5'd3, 5'd6));
        putInstr(immOp(opSw, 5'd0, 5'd6, sentinel[15:0]));
        putInstr(jumpTo(progLen));
        startProgram(stalls);
        awaitSentinel();
        checkWord(32'h100, r3);
        checkWord(32'h104, r4);
        checkWord(32'h108, r5);
        checkWord(sentinel, r6);
        for (i = 0; i < memWords; i++) begin
            addr = 32'(i) << 2;
            if (addr == 32'h100 || addr == 32'h104 || addr == 32'h108 || addr == sentinel) begin
                expectWrites(addr, 1);
            end else begin
                expectWrites(addr, 0);
            end
            if (stalls) begin
                checkWord(addr, aluSnapshot[i]);    // same image as the unstalled run
            end else begin
                aluSnapshot[i] = mem.dmem[i];
            end
        end
    endtask

    task automatic aluChainTest();
        $display("test: ALU chain");
        runAluChain(1'b0);
    endtask

    task automatic loadUseTest();
        wordT v1;
        wordT v2;
        $display("test: load-use");
        v1 = $urandom;
        v2 = $urandom;
        loads.delete();
        progLen = 0;
        putData(32'h120, v1);
        putData(32'h124, v2);
        putInstr(immOp(opLw, 5'd0, 5'd7, 16'h0120));
        putInstr(regOp(fnAddu, 5'd7, 5'd7, 5'd8));      // uses the load right away
        putInstr(immOp(opSw, 5'd0, 5'd8, 16'h0140));
        putInstr(immOp(opLw, 5'd0, 5'd9, 16'h0124));
        putInstr(immOp(opSw, 5'd0, 5'd9, 16'h0144));    // store data from the load
        putInstr(immOp(opSw, 5'd0, 5'd7, sentinel[15:0]));
        putInstr(jumpTo(progLen));
        startProgram(1'b0);
        awaitSentinel();
        checkWord(32'h140, v1 + v1);
        checkWord(32'h144, v2);
        checkWord(sentinel, v1);
    endtask

    task automatic branchTest();
        wordT a;
        wordT b;
        $display("test: branches");
        a = 32'd5;
        b = 32'd7;
        loads.delete();
        progLen = 0;
        putInstr(immOp(opOri, 5'd0, 5'd10, a[15:0]));
        putInstr(immOp(opOri, 5'd0, 5'd11, a[15:0]));
        putInstr(immOp(opBeq, 5'd10, 5'd11, 16'd2));   // taken, to word 5
        putInstr(immOp(opSw, 5'd0, 5'd10, 16'h0180));
        putInstr(immOp(opSw, 5'd0, 5'd11, 16'h0184));
        putInstr(immOp(opOri, 5'd0, 5'd12, b[15:0]));
        putInstr(immOp(opBeq, 5'd10, 5'd12, 16'd2));   // not taken
        putInstr(immOp(opSw, 5'd0, 5'd12, 16'h0188));
        putInstr(jumpTo(10));
        putInstr(immOp(opSw, 5'd0, 5'd10, 16'h018c));
        putInstr(regOp(fnAddu, 5'd12, 5'd10, 5'd13));
        putInstr(immOp(opSw, 5'd0, 5'd13, 16'h0190));
        putInstr(immOp(opSw, 5'd0, 5'd13, sentinel[15:0]));
        putInstr(jumpTo(progLen));
        startProgram(1'b0);
        awaitSentinel();
        expectWrites(32'h180, 0);
        expectWrites(32'h184, 0);
        expectWrites(32'h18c, 0);
        expectWrites(32'h188, 1);
        checkWord(32'h188, b);
        checkWord(32'h190, a + b);
        checkWord(sentinel, a + b);
    endtask

    task automatic mulTest();
        wordT a;
        wordT b;
        wordT p;
        wordT q;
        wordT r;
        $display("test: mul");
        a = {16'd0, 16'($urandom)};
        b = {16'd0, 16'($urandom)};
        p = a * b;
        q = p + a;
        r = q * q;      // low word only
        loads.delete();
        progLen = 0;
        putInstr(immOp(opOri, 5'd0, 5'd14, a[15:0]));
        putInstr(immOp(opOri, 5'd0, 5'd15, b[15:0]));
        putInstr(regOp(fnMul, 5'd14, 5'd15, 5'd16));
        putInstr(regOp(fnAddu, 5'd16, 5'd14, 5'd17));
        putInstr(regOp(fnMul, 5'd17, 5'd17, 5'd18));
        putInstr(immOp(opSw, 5'd0, 5'd16, 16'h01a0));
        putInstr(immOp(opSw, 5'd0, 5'd17, 16'h01a4));
        putInstr(immOp(opSw, 5'd0, 5'd18, 16'h01a8));
        putInstr(immOp(opSw, 5'd0, 5'd18, sentinel[15:0]));
        putInstr(jumpTo(progLen));
        startProgram(1'b0);
        awaitSentinel();
        checkWord(32'h1a0, p);
        checkWord(32'h1a4, q);
        checkWord(32'h1a8, r);
    endtask

    task automatic backPressureTest();
        $display("test: memory back-pressure");
        runAluChain(1'b1);
    endtask

    initial begin
        rstN      = 1'b0;
        stallEn   = 1'b0;
        clear     = 1'b0;
        loadEn    = 1'b0;
        loadInstr = 1'b0;
        loadIdx   = '0;
        loadData  = '0;
        errors    = 0;
        checks    = 0;
        progLen   = 0;
        void'($urandom(32'h36d5));
        aluChainTest();
        loadUseTest();
        branchTest();
        mulTest();
        backPressureTest();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // budget of 20 cycles per program word
    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired after %0d cycles", watchdogCycles);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/memModel.sv
`default_nettype none
`timescale 1ns/1ps

module memModel import isaPkg::*, pipePkg::*; #(
    parameter int   depth    = 256,
    parameter wordT sentinel = 32'h1fc
) (
    input  wire                     clk,
    input  wire wordT               iAddr,
    output wordT                    iData,
    output logic                    iStall,
    input  wire memReqT             dReq,
    output wordT                    dData,
    output logic                    dStall,
    input  wire                     stallEn,
    input  wire                     clear,
    input  wire                     loadEn,
    input  wire                     loadInstr,
    input  wire [$clog2(depth)-1:0] loadIdx,
    input  wire wordT               loadData,
    output logic                    sentinelSeen
);

    localparam int idxW = $clog2(depth);

    wordT            imem [depth];
    wordT            dmem [depth];
    logic [7:0]      wrCount [depth];   // accepted stores per word
    logic            iRnd = 1'b0;
    logic            dRnd = 1'b0;
    logic [idxW-1:0] dIdx;

    assign dIdx  = dReq.addr[idxW+1:2];
    assign iData = imem[iAddr[idxW+1:2]];   // both ports answer in the same cycle
    assign dData = dmem[dIdx];

    // new stall draw on every falling edge
    always @(negedge clk) begin
        iRnd <= ($urandom % 4) == 0;
        dRnd <= ($urandom % 3) == 0;
    end

    assign iStall = stallEn && iRnd;
    assign dStall = stallEn && dRnd;

    always @(posedge clk) begin
        if (clear) begin
            for (int i = 0; i < depth; i++) begin
                imem[i]    <= '0;                               // nop
                dmem[i]    <= 32'hdead_0000 ^ (32'(i) << 2);    // byte address in the low half
                wrCount[i] <= '0;
            end
            sentinelSeen <= 1'b0;
        end else if (loadEn) begin
            if (loadInstr) begin
                imem[loadIdx] <= loadData;
            end else begin
                dmem[loadIdx] <= loadData;
            end
        end else if (dReq.valid && dReq.write && !dStall) begin
            dmem[dIdx]    <= dReq.wdata;
            wrCount[dIdx] <= wrCount[dIdx] + 8'd1;
            if (dReq.addr == sentinel) begin
                sentinelSeen <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/coreTop.sv
`default_nettype none
`timescale 1ns/1ps

module coreTop import isaPkg::*, pipePkg::*; (
    input  wire       clk,
    input  wire       rstN,
    output wordT      iAddr,
    input  wire wordT iData,
    input  wire       iStall,
    output memReqT    dReq,
    input  wire wordT dData,
    input  wire       dStall
);

    wordT    pc;
    fdT      fdNext;
    fdT      fdCur;
    deT      deNext;
    deT      deCur;
    emT      emNext;
    emT      emCur;
    mwT      mwNext;
    mwT      mwCur;
    hazardT  haz;
    fwdSelT  fwdA;
    fwdSelT  fwdB;
    regAddrT raddrA;
    regAddrT raddrB;
    wordT    rdataA;
    wordT    rdataB;
    wordT    exResult;
    wordT    branchTarget;
    wordT    loadData;
    wordT    mValue;
    wordT    dKeep;
    logic    branchTaken;
    logic    mulBusy;
    logic    dAccept;
    logic    dDone;

    assign iAddr = pc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (!haz.stallF) begin
            pc <= branchTaken ? branchTarget : pc + 32'd4;
        end
    end

    assign fdNext = '{pc: pc, instr: iData};

    stageReg #(.payloadT(fdT), .resetVal('0)) fdReg (
        .clk(clk), .rstN(rstN), .stall(haz.stallD), .flush(haz.flushD),
        .d(fdNext), .q(fdCur)
    );

    decodeUnit decode (
        .fd(fdCur), .rdataA(rdataA), .rdataB(rdataB), .raddrA(raddrA), .raddrB(raddrB),
        .fwdA(fwdA), .fwdB(fwdB), .fwdE(exResult), .fwdM(mValue), .fwdW(mwCur.wbValue),
        .de(deNext), .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    stageReg #(.payloadT(deT), .resetVal('0)) deReg (
        .clk(clk), .rstN(rstN), .stall(haz.stallE), .flush(haz.flushE),
        .d(deNext), .q(deCur)
    );

    // mul count freezes only for memory stalls
    executeUnit execute (
        .clk(clk), .rstN(rstN), .de(deCur), .hold(iStall || dStall),
        .em(emNext), .result(exResult), .mulBusy(mulBusy)
    );

    stageReg #(.payloadT(emT), .resetVal('0)) emReg (
        .clk(clk), .rstN(rstN), .stall(haz.stallM), .flush(haz.flushM),
        .d(emNext), .q(emCur)
    );

    // memory may take the request while M is held by iStall or a mul,
    // so it goes out once and its load data is kept until M moves on
    assign dAccept = dReq.valid && !dStall;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dDone <= 1'b0;
        end else if (!haz.stallM) begin
            dDone <= 1'b0;
        end else if (dAccept) begin
            dDone <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dAccept) begin
            dKeep <= dData;
        end
    end

    assign dReq = '{
        valid: (emCur.ctrl.memRead || emCur.ctrl.memWrite) && !dDone,
        write: emCur.ctrl.memWrite,
        addr:  emCur.result,
        wdata: emCur.storeData
    };

    assign loadData = dDone ? dKeep : dData;
    assign mValue   = emCur.ctrl.memRead ? loadData : emCur.result;  // writeback select
    assign mwNext   = '{ctrl: emCur.ctrl, wbValue: mValue};

    stageReg #(.payloadT(mwT), .resetVal('0)) mwReg (
        .clk(clk), .rstN(rstN), .stall(haz.stallW), .flush(1'b0),
        .d(mwNext), .q(mwCur)
    );

    regFile regs (
        .clk(clk), .rstN(rstN), .raddrA(raddrA), .raddrB(raddrB),
        .rdataA(rdataA), .rdataB(rdataB), .we(mwCur.ctrl.regWrite),
        .waddr(mwCur.ctrl.writeReg), .wdata(mwCur.wbValue)
    );

    hazardUnit hazard (
        .rsD(raddrA), .rtD(raddrB), .ctrlE(deCur.ctrl), .ctrlM(emCur.ctrl),
        .ctrlW(mwCur.ctrl), .mulBusy(mulBusy), .iStall(iStall), .dStall(dStall),
        .branchTaken(branchTaken), .haz(haz), .fwdA(fwdA), .fwdB(fwdB)
    );

    // a request the memory is holding off must not change under it
    assert property (@(posedge clk) disable iff (!rstN)
        dReq.valid && dStall |=> $stable(dReq));

endmodule

`default_nettype wire

//--- logic/hazardUnit.sv
`default_nettype none
`timescale 1ns/1ps

module hazardUnit import isaPkg::*, pipePkg::*; (
    input  wire regAddrT rsD,
    input  wire regAddrT rtD,
    input  wire ctrlT    ctrlE,
    input  wire ctrlT    ctrlM,
    input  wire ctrlT    ctrlW,
    input  wire          mulBusy,
    input  wire          iStall,
    input  wire          dStall,
    input  wire          branchTaken,
    output hazardT       haz,
    output fwdSelT       fwdA,
    output fwdSelT       fwdB
);

    logic memStall;
    logic longStall;
    logic loadUse;

    function automatic logic hits(regAddrT src, ctrlT c);
        return (src != '0) && c.regWrite && (src == c.writeReg);
    endfunction

    function automatic fwdSelT pickSource(regAddrT src, ctrlT e, ctrlT m, ctrlT w);
        if (hits(src, e)) begin
            return e.memRead ? fwdNone : fromE;     // load data not back yet
        end
        if (hits(src, m)) begin
            return fromM;
        end
        if (hits(src, w)) begin
            return fromW;
        end
        return fwdNone;
    endfunction

    assign memStall  = iStall || dStall;
    assign longStall = memStall || mulBusy;
    assign loadUse   = ctrlE.memRead && (hits(rsD, ctrlE) || hits(rtD, ctrlE));

    assign fwdA = pickSource(rsD, ctrlE, ctrlM, ctrlW);
    assign fwdB = pickSource(rtD, ctrlE, ctrlM, ctrlW);

    always_comb begin
        haz.stallF = longStall || loadUse;
        haz.stallD = longStall || loadUse;
        haz.stallE = longStall;     // whole pipe freezes
        haz.stallM = longStall;
        haz.stallW = longStall;
        haz.flushD = branchTaken && !haz.stallD;   // drop the wrong-path fetch
        haz.flushE = loadUse && !haz.stallE;       // bubble behind the load
        haz.flushM = 1'b0;  // nothing in this subset squashes M
    end

endmodule

`default_nettype wire

//--- logic/executeUnit.sv
`default_nettype none
`timescale 1ns/1ps

module executeUnit import isaPkg::*, pipePkg::*; (
    input  wire       clk,
    input  wire       rstN,
    input  wire deT   de,
    input  wire       hold,
    output emT        em,
    output wordT      result,
    output logic      mulBusy
);

    logic [mulCntW-1:0] mulCnt;     // which byte of opB is being folded in
    logic [7:0]         mulByte;
    wordT               partial;
    wordT               mulAcc;
    wordT               mulSum;
    wordT               aluOut;

    // one byte of the multiplier per cycle, low byte first
    assign mulByte = 8'(de.opB >> (8 * mulCnt));
    assign partial = (de.opA * wordT'(mulByte)) << (8 * mulCnt);
    assign mulSum  = ((mulCnt == '0) ? '0 : mulAcc) + partial;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mulCnt <= '0;
        end else if (de.ctrl.isMul && !hold) begin
            if (mulCnt == mulCntW'(mulCycles - 1)) begin
                mulCnt <= '0;   // E moves on at this edge
            end else begin
                mulCnt <= mulCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (de.ctrl.isMul && !hold) begin
            mulAcc <= mulSum;
        end
    end

    // low on the last step, when mulSum holds the full product
    assign mulBusy = de.ctrl.isMul && (mulCnt != mulCntW'(mulCycles - 1));

    always_comb begin
        case (de.ctrl.aluOp)
            aluSub:  aluOut = de.opA - de.opB;
            aluOr:   aluOut = de.opA | de.opB;
            aluMul:  aluOut = mulSum;
            default: aluOut = de.opA + de.opB;
        endcase
    end

    assign result = aluOut;
    assign em = '{ctrl: de.ctrl, result: aluOut, storeData: de.storeData};

    // a mul keeps E until its count wraps back to zero
    assert property (@(posedge clk) disable iff (!rstN) mulCnt != '0 |-> de.ctrl.isMul);

endmodule

`default_nettype wire

//--- logic/decodeUnit.sv
`default_nettype none
`timescale 1ns/1ps

module decodeUnit import isaPkg::*, pipePkg::*; (
    input  wire fdT     fd,
    input  wire wordT   rdataA,
    input  wire wordT   rdataB,
    output regAddrT     raddrA,
    output regAddrT     raddrB,
    input  wire fwdSelT fwdA,
    input  wire fwdSelT fwdB,
    input  wire wordT   fwdE,
    input  wire wordT   fwdM,
    input  wire wordT   fwdW,
    output deT          de,
    output logic        branchTaken,
    output wordT        branchTarget
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddrT    rd;
    wordT       pcPlus4;
    wordT       immSext;
    wordT       immZext;
    wordT       srcA;
    wordT       srcB;
    ctrlT       ctrl;
    logic       isBeq;
    logic       isJump;

    function automatic wordT pickOperand(fwdSelT sel, wordT fileVal, wordT eVal,
                                         wordT mVal, wordT wVal);
        case (sel)
            fromE:   return eVal;
            fromM:   return mVal;
            fromW:   return wVal;
            default: return fileVal;
        endcase
    endfunction

    assign opcode  = fd.instr[31:26];
    assign funct   = fd.instr[5:0];
    assign raddrA  = fd.instr[25:21];  // rs
    assign raddrB  = fd.instr[20:16];  // rt
    assign rd      = fd.instr[15:11];
    assign immSext = {{16{fd.instr[15]}}, fd.instr[15:0]};
    assign immZext = {16'd0, fd.instr[15:0]};
    assign pcPlus4 = fd.pc + 32'd4;

    assign srcA = pickOperand(fwdA, rdataA, fwdE, fwdM, fwdW);
    assign srcB = pickOperand(fwdB, rdataB, fwdE, fwdM, fwdW);

    always_comb begin
        ctrl   = '0;    // anything unknown decodes as a nop
        isBeq  = 1'b0;
        isJump = 1'b0;
        case (opcode)
            opSpecial: begin
                ctrl.writeReg = rd;
                ctrl.regWrite = (funct == fnAddu) || (funct == fnSubu) || (funct == fnMul);
                ctrl.isMul    = (funct == fnMul);
                case (funct)
                    fnSubu:  ctrl.aluOp = aluSub;
                    fnMul:   ctrl.aluOp = aluMul;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            opOri: begin
                ctrl.aluOp    = aluOr;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.writeReg = raddrB;
            end
            opLw: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.writeReg = raddrB;
            end
            opSw: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opBeq:   isBeq  = 1'b1;
            opJ:     isJump = 1'b1;
            default: ;
        endcase
    end

    assign de = '{
        ctrl:      ctrl,
        opA:       srcA,
        opB:       !ctrl.useImm ? srcB : ((opcode == opOri) ? immZext : immSext),
        storeData: srcB
    };

    // resolved here so a taken branch costs only the F slot
    assign branchTaken  = isJump || (isBeq && srcA == srcB);
    assign branchTarget = isJump ? {pcPlus4[31:28], fd.instr[25:0], 2'b00}
                                 : pcPlus4 + {immSext[29:0], 2'b00};

endmodule

`default_nettype wire

//--- logic/stageReg.sv
`default_nettype none
`timescale 1ns/1ps

module stageReg #(
    parameter type     payloadT = logic,
    parameter payloadT resetVal = '0
) (
    input  wire          clk,
    input  wire          rstN,
    input  wire          stall,
    input  wire          flush,
    input  wire payloadT d,
    output payloadT      q
);

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            q <= resetVal;      // bubble
        end else if (!stall) begin
            q <= d;
        end
    end

    // a held stage must keep its instruction, so hazard logic never squashes it
    assert property (@(posedge clk) disable iff (!rstN) !(stall && flush));

endmodule

`default_nettype wire

//--- logic/regFile.sv
`default_nettype none
`timescale 1ns/1ps

module regFile import isaPkg::*; (
    input  wire          clk,
    input  wire          rstN,
    input  wire regAddrT raddrA,
    input  wire regAddrT raddrB,
    output wordT         rdataA,
    output wordT         rdataB,
    input  wire          we,
    input  wire regAddrT waddr,
    input  wire wordT    wdata
);

    wordT regs [32];

    // no write lands while the core sits in reset
    always_ff @(posedge clk) begin
        if (rstN && we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // $0 reads as zero whatever the array holds
    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

`default_nettype wire

//--- logic/pipePkg.sv
`default_nettype none

package pipePkg;

    import isaPkg::*;

    typedef struct packed {
        wordT pc;
        wordT instr;
    } fdT;

    typedef struct packed {
        ctrlT ctrl;
        wordT opA;
        wordT opB;          // already muxed with the immediate
        wordT storeData;
    } deT;

    typedef struct packed {
        ctrlT ctrl;
        wordT result;       // ALU result, or address for lw/sw
        wordT storeData;
    } emT;

    typedef struct packed {
        ctrlT ctrl;
        wordT wbValue;
    } mwT;

    // decode operand source, E wins over M wins over W
    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fromW   = 2'd1,
        fromM   = 2'd2,
        fromE   = 2'd3
    } fwdSelT;

    typedef struct packed {
        logic stallF;
        logic stallD;
        logic stallE;
        logic stallM;
        logic stallW;
        logic flushD;
        logic flushE;
        logic flushM;
    } hazardT;

    typedef struct packed {
        logic valid;
        logic write;
        wordT addr;
        wordT wdata;
    } memReqT;

endpackage

`default_nettype wire

//--- logic/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opOri     = 6'h0d,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    // funct field under opSpecial
    typedef enum logic [5:0] {
        fnMul  = 6'h18,     // mult slot, but the product goes to rd
        fnAddu = 6'h21,
        fnSubu = 6'h23
    } functT;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluMul
    } aluOpT;

    typedef struct packed {
        aluOpT   aluOp;
        logic    useImm;    // operand B is the immediate
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    isMul;
        regAddrT writeReg;
    } ctrlT;

    localparam int mulCycles = 4;   // E occupancy of one mul
    localparam int mulCntW   = $clog2(mulCycles + 1);

endpackage

`default_nettype wire
